/* hw/isu_pkg.sv */
package isu_pkg;

    localparam int XLEN      = 64;
    localparam int PREG_W    = 5;
    localparam int LREG_W    = 5;
    localparam int ROB_IDX_W = 3;
    localparam int OP_W      = 16;

    localparam int NUM_PREG  = 1 << PREG_W;
    localparam int ROB_DEPTH = 1 << ROB_IDX_W;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [XLEN-1:0]    pc_t;
    typedef logic [PREG_W-1:0]  preg_t;
    typedef logic [LREG_W-1:0]  lreg_t;
    // index plus wrap bit
    typedef logic [ROB_IDX_W:0] rob_id_t;
    typedef logic [OP_W-1:0]    op_t;

    typedef struct packed {
        pc_t   pc;
        lreg_t lrd;
        preg_t prd;
        preg_t old_prd;
        logic  need_to_wb;
        preg_t prs1;
        preg_t prs2;
        logic  src1_is_reg;
        logic  src2_is_reg;
        xlen_t imm;
        op_t   op;
    } disp_pkt_t;

    typedef struct packed {
        rob_id_t   robid;
        disp_pkt_t inst;
    } issue_pkt_t;

    typedef struct packed {
        logic    valid;
        rob_id_t robid;
        preg_t   prd;
        logic    need_to_wb;
        xlen_t   result;
    } wb_t;

    typedef struct packed {
        pc_t     pc;
        lreg_t   lrd;
        preg_t   prd;
        preg_t   old_prd;
        logic    need_to_wb;
        rob_id_t robid;
    } commit_t;

    // writeback that produces preg p this cycle
    function automatic logic wb_hits(wb_t wb, preg_t p);
        return wb.valid && wb.need_to_wb && (wb.prd == p);
    endfunction

endpackage

/* hw/dispatch.sv */
`timescale 1ns/1ps

module dispatch
    import isu_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  disp_pkt_t  in_pkt,
    input  logic       rob_can_enq,
    input  rob_id_t    rob_robid,
    output logic       rob_enq,
    output disp_pkt_t  rob_pkt,
    input  logic       isq_can_enq,
    output logic       isq_enq_valid,
    output issue_pkt_t isq_pkt,
    output logic       isq_src1_rdy,
    output logic       isq_src2_rdy,
    output preg_t      bt_raddr1,
    output preg_t      bt_raddr2,
    input  logic       bt_busy1,
    input  logic       bt_busy2,
    output logic       bt_alloc_en,
    output preg_t      bt_alloc_addr
);
    logic fire;

    // ready only when both targets have room
    assign in_ready = rob_can_enq && isq_can_enq;
    assign fire     = in_valid && in_ready;

    assign rob_enq = fire;
    assign rob_pkt = in_pkt;

    assign isq_enq_valid = fire;
    assign isq_pkt       = '{robid: rob_robid, inst: in_pkt};

    assign bt_raddr1 = in_pkt.prs1;
    assign bt_raddr2 = in_pkt.prs2;

    // immediates never wait
    assign isq_src1_rdy = !in_pkt.src1_is_reg || !bt_busy1;
    assign isq_src2_rdy = !in_pkt.src2_is_reg || !bt_busy2;

    assign bt_alloc_en   = fire && in_pkt.need_to_wb;
    assign bt_alloc_addr = in_pkt.prd;

    // a refused instruction is offered again unchanged
    a_in_held: assert property (
        @(posedge clock) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_pkt))
    );

endmodule

/* hw/rob.sv */
`timescale 1ns/1ps

module rob
    import isu_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      enq,
    input  disp_pkt_t enq_pkt,
    output logic      can_enq,
    output rob_id_t   alloc_robid,
    input  wb_t       intwb,
    input  wb_t       memwb,
    output logic      commit_valid,
    output commit_t   commit
);
    commit_t              entry_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    rob_id_t              head_q;
    rob_id_t              tail_q;
    logic [ROB_IDX_W-1:0] head_idx;
    logic [ROB_IDX_W-1:0] tail_idx;
    logic                 full;
    logic                 empty;

    assign head_idx = head_q[ROB_IDX_W-1:0];
    assign tail_idx = tail_q[ROB_IDX_W-1:0];

    // same index, different lap
    assign full  = (head_idx == tail_idx) && (head_q[ROB_IDX_W] != tail_q[ROB_IDX_W]);
    assign empty = (head_q == tail_q);

    assign can_enq     = !full;
    assign alloc_robid = tail_q;

    assign commit_valid = !empty && done_q[head_idx];
    assign commit       = entry_q[head_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            done_q <= '0;
        end else begin
            if (enq) begin
                tail_q           <= tail_q + rob_id_t'(1);
                done_q[tail_idx] <= 1'b0;
            end
            if (intwb.valid) begin
                done_q[intwb.robid[ROB_IDX_W-1:0]] <= 1'b1;
            end
            if (memwb.valid) begin
                done_q[memwb.robid[ROB_IDX_W-1:0]] <= 1'b1;
            end
            if (commit_valid) begin
                head_q <= head_q + rob_id_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            entry_q[tail_idx] <= '{
                pc:         enq_pkt.pc,
                lrd:        enq_pkt.lrd,
                prd:        enq_pkt.prd,
                old_prd:    enq_pkt.old_prd,
                need_to_wb: enq_pkt.need_to_wb,
                robid:      tail_q
            };
        end
    end

    // id lies between head and tail, wrap bit included
    function automatic logic in_flight(rob_id_t id);
        rob_id_t off;
        rob_id_t used;
        off  = id - head_q;
        used = tail_q - head_q;
        return off < used;
    endfunction

    a_intwb_allocated: assert property (
        @(posedge clock) disable iff (!rst_n)
        intwb.valid |-> in_flight(intwb.robid)
    );

    a_memwb_allocated: assert property (
        @(posedge clock) disable iff (!rst_n)
        memwb.valid |-> in_flight(memwb.robid)
    );

endmodule

/* hw/busy_table.sv */
`timescale 1ns/1ps

module busy_table
    import isu_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  preg_t raddr1,
    input  preg_t raddr2,
    output logic  busy1,
    output logic  busy2,
    input  logic  alloc_en,
    input  preg_t alloc_addr,
    input  wb_t   intwb,
    input  wb_t   memwb
);
    logic [NUM_PREG-1:0] busy_q;

    // a register freed this cycle already reads as free
    assign busy1 = busy_q[raddr1] && !wb_hits(intwb, raddr1) && !wb_hits(memwb, raddr1);
    assign busy2 = busy_q[raddr2] && !wb_hits(intwb, raddr2) && !wb_hits(memwb, raddr2);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            for (int i = 0; i < NUM_PREG; i++) begin
                // allocation wins over a free of the same preg
                if (alloc_en && (alloc_addr == preg_t'(i))) begin
                    busy_q[i] <= 1'b1;
                end else if (wb_hits(intwb, preg_t'(i)) || wb_hits(memwb, preg_t'(i))) begin
                    busy_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

/* hw/int_isq.sv */
`timescale 1ns/1ps

module int_isq
    import isu_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       enq_valid,
    input  issue_pkt_t enq_pkt,
    input  logic       enq_src1_rdy,
    input  logic       enq_src2_rdy,
    output logic       can_enq,
    input  wb_t        intwb,
    input  wb_t        memwb,
    output logic       deq_valid,
    input  logic       deq_ready,
    output issue_pkt_t deq_pkt,
    output preg_t      rd_addr1,
    output preg_t      rd_addr2
);
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    issue_pkt_t       pkt_q [DEPTH];
    issue_pkt_t       pkt_n [DEPTH];
    logic [DEPTH-1:0] vld_q;
    logic [DEPTH-1:0] vld_n;
    logic [DEPTH-1:0] rdy1_q;
    logic [DEPTH-1:0] rdy1_n;
    logic [DEPTH-1:0] rdy2_q;
    logic [DEPTH-1:0] rdy2_n;
    logic [DEPTH-1:0] req;
    logic [IDX_W-1:0] oldest;
    logic [IDX_W-1:0] sel;
    logic [IDX_W-1:0] hold_idx_q;
    logic             hold_q;
    logic             any_req;
    logic             fire;

    assign can_enq = !vld_q[DEPTH-1];
    assign req     = vld_q & rdy1_q & rdy2_q;

    // slot 0 is the oldest
    always_comb begin
        oldest  = '0;
        any_req = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                oldest  = IDX_W'(i);
                any_req = 1'b1;
            end
        end
    end

    // keep presenting the stalled entry even if an older one wakes
    assign sel       = hold_q ? hold_idx_q : oldest;
    assign deq_valid = hold_q || any_req;
    assign deq_pkt   = pkt_q[sel];
    assign fire      = deq_valid && deq_ready;

    assign rd_addr1 = deq_pkt.inst.prs1;
    assign rd_addr2 = deq_pkt.inst.prs2;

    always_comb begin
        int   src;
        logic placed;
        placed = 1'b0;
        // collapse above the issued slot, wake up on the way
        for (int i = 0; i < DEPTH; i++) begin
            src = (fire && (i >= int'(sel))) ? i + 1 : i;
            if (src < DEPTH) begin
                vld_n[i]  = vld_q[src];
                pkt_n[i]  = pkt_q[src];
                rdy1_n[i] = rdy1_q[src] || wb_hits(intwb, pkt_q[src].inst.prs1)
                                        || wb_hits(memwb, pkt_q[src].inst.prs1);
                rdy2_n[i] = rdy2_q[src] || wb_hits(intwb, pkt_q[src].inst.prs2)
                                        || wb_hits(memwb, pkt_q[src].inst.prs2);
            end else begin
                vld_n[i]  = 1'b0;
                pkt_n[i]  = pkt_q[i];
                rdy1_n[i] = 1'b0;
                rdy2_n[i] = 1'b0;
            end
        end
        // new entry goes to the first free slot
        for (int i = 0; i < DEPTH; i++) begin
            if (enq_valid && !placed && !vld_n[i]) begin
                vld_n[i]  = 1'b1;
                pkt_n[i]  = enq_pkt;
                rdy1_n[i] = enq_src1_rdy;
                rdy2_n[i] = enq_src2_rdy;
                placed    = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            vld_q      <= '0;
            rdy1_q     <= '0;
            rdy2_q     <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            vld_q      <= vld_n;
            rdy1_q     <= rdy1_n;
            rdy2_q     <= rdy2_n;
            hold_q     <= deq_valid && !deq_ready;
            hold_idx_q <= sel;
        end
    end

    always_ff @(posedge clock) begin
        pkt_q <= pkt_n;
    end

    a_deq_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        (deq_valid && !deq_ready) |=> (deq_valid && $stable(deq_pkt))
    );

endmodule

/* hw/pregfile.sv */
`timescale 1ns/1ps

module pregfile
    import isu_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  wb_t   intwb,
    input  wb_t   memwb,
    input  preg_t raddr1,
    input  preg_t raddr2,
    output xlen_t rdata1,
    output xlen_t rdata2
);
    xlen_t regs_q [NUM_PREG];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PREG; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            // ports never collide on one preg
            for (int i = 0; i < NUM_PREG; i++) begin
                if (wb_hits(intwb, preg_t'(i))) begin
                    regs_q[i] <= intwb.result;
                end else if (wb_hits(memwb, preg_t'(i))) begin
                    regs_q[i] <= memwb.result;
                end
            end
        end
    end

    assign rdata1 = regs_q[raddr1];
    assign rdata2 = regs_q[raddr2];

endmodule

/* hw/isu_top.sv */
`timescale 1ns/1ps

module isu_top
    import isu_pkg::*;
#(
    parameter int ISQ_DEPTH = 4
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  disp_pkt_t  in_pkt,
    input  wb_t        intwb,
    input  wb_t        memwb,
    output logic       issue_valid,
    input  logic       issue_ready,
    output issue_pkt_t issue_pkt,
    output xlen_t      issue_src1,
    output xlen_t      issue_src2,
    output logic       commit_valid,
    output commit_t    commit
);
    logic       rob_can_enq;
    rob_id_t    rob_robid;
    logic       rob_enq;
    disp_pkt_t  rob_pkt;
    logic       isq_can_enq;
    logic       isq_enq_valid;
    issue_pkt_t isq_pkt;
    logic       isq_src1_rdy;
    logic       isq_src2_rdy;
    preg_t      bt_raddr1;
    preg_t      bt_raddr2;
    logic       bt_busy1;
    logic       bt_busy2;
    logic       bt_alloc_en;
    preg_t      bt_alloc_addr;
    preg_t      prf_raddr1;
    preg_t      prf_raddr2;

    dispatch u_dispatch (
        .clock         (clock),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pkt        (in_pkt),
        .rob_can_enq   (rob_can_enq),
        .rob_robid     (rob_robid),
        .rob_enq       (rob_enq),
        .rob_pkt       (rob_pkt),
        .isq_can_enq   (isq_can_enq),
        .isq_enq_valid (isq_enq_valid),
        .isq_pkt       (isq_pkt),
        .isq_src1_rdy  (isq_src1_rdy),
        .isq_src2_rdy  (isq_src2_rdy),
        .bt_raddr1     (bt_raddr1),
        .bt_raddr2     (bt_raddr2),
        .bt_busy1      (bt_busy1),
        .bt_busy2      (bt_busy2),
        .bt_alloc_en   (bt_alloc_en),
        .bt_alloc_addr (bt_alloc_addr)
    );

    rob u_rob (
        .clock        (clock),
        .rst_n        (rst_n),
        .enq          (rob_enq),
        .enq_pkt      (rob_pkt),
        .can_enq      (rob_can_enq),
        .alloc_robid  (rob_robid),
        .intwb        (intwb),
        .memwb        (memwb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    busy_table u_busy_table (
        .clock      (clock),
        .rst_n      (rst_n),
        .raddr1     (bt_raddr1),
        .raddr2     (bt_raddr2),
        .busy1      (bt_busy1),
        .busy2      (bt_busy2),
        .alloc_en   (bt_alloc_en),
        .alloc_addr (bt_alloc_addr),
        .intwb      (intwb),
        .memwb      (memwb)
    );

    int_isq #(
        .DEPTH (ISQ_DEPTH)
    ) u_int_isq (
        .clock        (clock),
        .rst_n        (rst_n),
        .enq_valid    (isq_enq_valid),
        .enq_pkt      (isq_pkt),
        .enq_src1_rdy (isq_src1_rdy),
        .enq_src2_rdy (isq_src2_rdy),
        .can_enq      (isq_can_enq),
        .intwb        (intwb),
        .memwb        (memwb),
        .deq_valid    (issue_valid),
        .deq_ready    (issue_ready),
        .deq_pkt      (issue_pkt),
        .rd_addr1     (prf_raddr1),
        .rd_addr2     (prf_raddr2)
    );

    // operands go straight to the execution unit
    pregfile u_pregfile (
        .clock  (clock),
        .rst_n  (rst_n),
        .intwb  (intwb),
        .memwb  (memwb),
        .raddr1 (prf_raddr1),
        .raddr2 (prf_raddr2),
        .rdata1 (issue_src1),
        .rdata2 (issue_src2)
    );

endmodule

/* verif/tb_isu.sv */
`timescale 1ns/1ps

module tb_isu
    import isu_pkg::*;
();
    localparam int ISQ_DEPTH     = 4;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_LREG      = 8;
    localparam int NUM_ID        = 1 << (ROB_IDX_W + 1);
    localparam int IDLE_CYCLES   = 20;
    localparam int RANDOM_CYCLES = 400;
    localparam int CHAIN_CYCLES  = 300;
    localparam int STALL_CYCLES  = 40;
    localparam int DRAIN_LIMIT   = 200;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES
                                 + CHAIN_CYCLES + STALL_CYCLES + 4 * DRAIN_LIMIT;

    logic       clock;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    disp_pkt_t  in_pkt;
    wb_t        intwb;
    wb_t        memwb;
    logic       issue_valid;
    logic       issue_ready;
    issue_pkt_t issue_pkt;
    xlen_t      issue_src1;
    xlen_t      issue_src2;
    logic       commit_valid;
    commit_t    commit;

    integer seed;

    // reference model
    xlen_t               model_regs [NUM_PREG];
    logic [NUM_PREG-1:0] model_busy;
    preg_t               rename_map [NUM_LREG];
    preg_t               free_pool [$];
    rob_id_t             order_q [$];
    disp_pkt_t           inst_by_id [NUM_ID];
    logic [NUM_ID-1:0]   issued;
    logic [NUM_ID-1:0]   written;
    rob_id_t             next_robid;
    int                  isq_count;
    rob_id_t             wb_id_q [$];
    int                  wb_due_q [$];
    lreg_t               last_lrd;
    int                  built;
    int                  cycle;
    logic                accepted;
    int                  valid_pct;
    int                  ready_pct;
    int                  chain_mode;
    logic                ready_fell;
    int                  errors;
    int                  errors_at_start;
    int                  tests_run;
    int                  tests_failed;

    isu_top #(
        .ISQ_DEPTH (ISQ_DEPTH)
    ) u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pkt       (in_pkt),
        .intwb        (intwb),
        .memwb        (memwb),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_pkt    (issue_pkt),
        .issue_src1   (issue_src1),
        .issue_src2   (issue_src2),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_mismatch(string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic int unsigned rand_below(int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic xlen_t rand_xlen();
        xlen_t v;
        v[63:32] = $random(seed);
        v[31:0]  = $random(seed);
        return v;
    endfunction

    // rename against the model map, fresh prd from the head of the free pool
    function automatic disp_pkt_t build_pkt();
        disp_pkt_t p;
        lreg_t     l1;
        lreg_t     l2;
        p           = '0;
        p.lrd       = lreg_t'(rand_below(NUM_LREG));
        l1          = chain_mode != 0 ? last_lrd : lreg_t'(rand_below(NUM_LREG));
        l2          = lreg_t'(rand_below(NUM_LREG));
        p.pc        = 64'h8000_0000 + 64'(built) * 64'd4;
        p.prd       = free_pool[0];
        p.old_prd   = rename_map[p.lrd];
        p.need_to_wb  = 1'b1;
        p.prs1        = rename_map[l1];
        p.prs2        = rename_map[l2];
        p.src1_is_reg = rand_below(8) != 0;
        p.src2_is_reg = rand_below(4) != 0;
        p.imm         = rand_xlen();
        p.op          = op_t'(rand_below(65536));
        built++;
        return p;
    endfunction

    function automatic logic is_in_flight(rob_id_t id);
        foreach (order_q[i]) begin
            if (order_q[i] == id) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // at most one due writeback per port, ports picked at random
    task automatic drive_writebacks();
        int   k;
        logic mem_first;
        wb_t  w;
        intwb     = '0;
        memwb     = '0;
        mem_first = rand_below(2) != 0;
        for (int n = 0; n < 2; n++) begin
            k = -1;
            for (int i = 0; i < wb_id_q.size(); i++) begin
                if (k < 0 && wb_due_q[i] <= cycle) begin
                    k = i;
                end
            end
            if (k >= 0) begin
                w.valid      = 1'b1;
                w.robid      = wb_id_q[k];
                w.prd        = inst_by_id[w.robid].prd;
                w.need_to_wb = 1'b1;
                w.result     = rand_xlen();
                if ((n == 0) == mem_first) begin
                    memwb = w;
                end else begin
                    intwb = w;
                end
                wb_id_q.delete(k);
                wb_due_q.delete(k);
            end
        end
    endtask

    task automatic drive_inputs();
        cycle++;
        if (accepted) begin
            in_valid = 1'b0;
            accepted = 1'b0;
        end
        // hold the packet until it is taken
        if (!in_valid && rand_below(100) < valid_pct) begin
            in_pkt   = build_pkt();
            in_valid = 1'b1;
        end
        issue_ready = rand_below(100) < ready_pct;
        drive_writebacks();
    endtask

    function automatic void apply_writeback(wb_t w);
        if (w.valid) begin
            model_regs[w.prd] = w.result;
            model_busy[w.prd] = 1'b0;
            written[w.robid]  = 1'b1;
        end
    endfunction

    task automatic check_cycle();
        logic      exp_ready;
        rob_id_t   id;
        disp_pkt_t p;
        exp_ready = (order_q.size() < ROB_DEPTH) && (isq_count < ISQ_DEPTH);
        if (in_ready !== exp_ready) begin
            report_mismatch($sformatf("in_ready %b, expected %b with %0d in rob, %0d in queue",
                                      in_ready, exp_ready, order_q.size(), isq_count));
        end
        if (in_ready !== 1'b1) begin
            ready_fell = 1'b1;
        end
        if (commit_valid === 1'b1) begin
            if (order_q.size() == 0) begin
                report_failure("commit seen with no instruction in flight");
            end else begin
                id = order_q[0];
                p  = inst_by_id[id];
                if (commit.robid !== id || commit.pc !== p.pc || commit.lrd !== p.lrd
                        || commit.prd !== p.prd || commit.old_prd !== p.old_prd
                        || commit.need_to_wb !== p.need_to_wb) begin
                    report_mismatch($sformatf("commit robid %0d pc %h, expected robid %0d pc %h",
                                              commit.robid, commit.pc, id, p.pc));
                end
                if (!written[id]) begin
                    report_mismatch($sformatf("robid %0d committed before its writeback", id));
                end
                void'(order_q.pop_front());
                free_pool.push_back(p.old_prd);
            end
        end
        if (issue_valid === 1'b1 && issue_ready) begin
            id = issue_pkt.robid;
            p  = inst_by_id[id];
            if (!is_in_flight(id) || issued[id]) begin
                report_mismatch($sformatf("issued robid %0d is not waiting in the model", id));
            end else begin
                if (issue_pkt.inst !== p) begin
                    report_mismatch($sformatf("issued packet for robid %0d differs", id));
                end
                if ((p.src1_is_reg && model_busy[p.prs1])
                        || (p.src2_is_reg && model_busy[p.prs2])) begin
                    report_mismatch($sformatf("robid %0d issued with a busy source", id));
                end
                if (p.src1_is_reg && issue_src1 !== model_regs[p.prs1]) begin
                    report_mismatch($sformatf("src1 %h, expected %h for p%0d",
                                              issue_src1, model_regs[p.prs1], p.prs1));
                end
                if (p.src2_is_reg && issue_src2 !== model_regs[p.prs2]) begin
                    report_mismatch($sformatf("src2 %h, expected %h for p%0d",
                                              issue_src2, model_regs[p.prs2], p.prs2));
                end
                issued[id] = 1'b1;
                isq_count--;
                wb_id_q.push_back(id);
                wb_due_q.push_back(cycle + 1 + int'(rand_below(6)));
            end
        end
        if (in_valid === 1'b1 && in_ready === 1'b1) begin
            id                   = next_robid;
            inst_by_id[id]       = in_pkt;
            issued[id]           = 1'b0;
            written[id]          = 1'b0;
            model_busy[in_pkt.prd] = 1'b1;
            rename_map[in_pkt.lrd] = in_pkt.prd;
            last_lrd             = in_pkt.lrd;
            void'(free_pool.pop_front());
            order_q.push_back(id);
            next_robid           = next_robid + rob_id_t'(1);
            isq_count++;
            accepted             = 1'b1;
        end
        apply_writeback(intwb);
        apply_writeback(memwb);
    endtask

    task automatic run_cycle();
        @(posedge clock);
        #1;
        drive_inputs();
        @(negedge clock);
        check_cycle();
    endtask

    task automatic drain();
        int n;
        valid_pct = 0;
        ready_pct = 100;
        n         = 0;
        while (((in_valid && !accepted) || order_q.size() != 0) && n < DRAIN_LIMIT) begin
            run_cycle();
            n++;
        end
        if ((in_valid && !accepted) || order_q.size() != 0) begin
            report_failure($sformatf("%0d instructions still in flight after %0d drain cycles",
                                     order_q.size(), DRAIN_LIMIT));
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_at_start);
        end
    endtask

    initial begin
        repeat (20 * TOTAL_CYCLES) @(posedge clock);
        $display("Error: watchdog expired after %0d cycles", 20 * TOTAL_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed         = 32'hacacbeb7;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_pkt       = '0;
        issue_ready  = 1'b0;
        intwb        = '0;
        memwb        = '0;
        model_busy   = '0;
        issued       = '0;
        written      = '0;
        next_robid   = '0;
        isq_count    = 0;
        last_lrd     = '0;
        built        = 0;
        cycle        = 0;
        accepted     = 1'b0;
        chain_mode   = 0;
        ready_fell   = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        // logical l starts in p(l), the rest are free
        for (int i = 0; i < NUM_PREG; i++) begin
            model_regs[i] = '0;
            if (i < NUM_LREG) begin
                rename_map[i] = preg_t'(i);
            end else begin
                free_pool.push_back(preg_t'(i));
            end
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;

        begin_test();
        valid_pct = 0;
        ready_pct = 50;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            run_cycle();
            if (issue_valid !== 1'b0 || commit_valid !== 1'b0) begin
                report_mismatch("issue_valid or commit_valid high with nothing dispatched");
            end
            if (in_ready !== 1'b1) begin
                report_mismatch("in_ready low after reset");
            end
        end
        end_test("reset_idle");

        begin_test();
        valid_pct = 70;
        ready_pct = 70;
        repeat (RANDOM_CYCLES) run_cycle();
        drain();
        end_test("random_mix");

        begin_test();
        chain_mode = 1;
        valid_pct  = 90;
        ready_pct  = 90;
        repeat (CHAIN_CYCLES) run_cycle();
        drain();
        chain_mode = 0;
        end_test("dependency_chain");

        begin_test();
        valid_pct  = 100;
        ready_pct  = 0;
        ready_fell = 1'b0;
        repeat (STALL_CYCLES) run_cycle();
        if (!ready_fell) begin
            report_failure("in_ready never fell while issue was stalled");
        end
        if (isq_count != ISQ_DEPTH && order_q.size() != ROB_DEPTH) begin
            report_failure("neither the issue queue nor the ROB filled during the stall");
        end
        drain();
        end_test("backpressure");

        $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/isu_pkg.sv
hw/dispatch.sv
hw/rob.sv
hw/busy_table.sv
hw/int_isq.sv
hw/pregfile.sv
hw/isu_top.sv
verif/tb_isu.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_isu -f verilog.f -o sim_isu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_isu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1
